/* common/alarm_pkg.sv */
package alarm_pkg;

    localparam int SWITCH_W   = 9;
    localparam int COUNT_W    = 17;  // wide enough for 51100 centiseconds
    localparam int CS_PER_SEC = 100;
    localparam int NUM_DIGITS = 5;

    // timing at a 100 MHz board clock
    localparam int CLKS_PER_TICK_DEFAULT  = 1_000_000;  // one centisecond
    localparam int DEBOUNCE_CLKS_DEFAULT  = 1_000_000;  // 10 ms of stable level
    localparam int SCAN_CLKS_DEFAULT      = 100_000;    // 1 ms per digit
    localparam int TONE_HALF_CLKS_DEFAULT = 25_000;     // 2 kHz tone
    localparam int BLINK_TICKS            = 50;         // half a second per blink phase

    typedef logic [COUNT_W-1:0] count_t;

    // raw button levels or one-cycle press pulses
    typedef struct packed {
        logic pause;
        logic clear;
    } buttons_t;

    typedef enum logic [1:0] {
        SET,
        RUN,
        PAUSE,
        BEEP
    } timer_state_t;

    // registered controller outputs
    typedef struct packed {
        count_t count_cs;
        logic   flash;
        logic   buzz;
    } timer_status_t;

    // digit 0 is hundredths, digit 4 is hundreds of seconds
    typedef logic [NUM_DIGITS-1:0][3:0] bcd_digits_t;

endpackage

/* verilog/button_conditioner.sv */
`timescale 1ns/1ps

module button_conditioner #(
    parameter int DEBOUNCE_CLKS = alarm_pkg::DEBOUNCE_CLKS_DEFAULT
) (
    input  logic                clk,
    input  logic                rst,
    input  alarm_pkg::buttons_t buttons,
    output alarm_pkg::buttons_t presses
);

    logic [$bits(alarm_pkg::buttons_t)-1:0] raw;
    logic [$bits(alarm_pkg::buttons_t)-1:0] sync_q1;
    logic [$bits(alarm_pkg::buttons_t)-1:0] sync_q2;
    logic [$bits(alarm_pkg::buttons_t)-1:0] stable;   // accepted debounced level
    logic [$bits(alarm_pkg::buttons_t)-1:0] press_q;
    logic [$bits(alarm_pkg::buttons_t)-1:0][$clog2(DEBOUNCE_CLKS+1)-1:0] hold_cnt;

    assign raw     = buttons;
    assign presses = press_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            sync_q1  <= '0;
            sync_q2  <= '0;
            stable   <= '0;
            press_q  <= '0;
            hold_cnt <= '0;
        end else begin
            sync_q1 <= raw;      // two-flop synchronizer
            sync_q2 <= sync_q1;
            press_q <= '0;
            for (int i = 0; i < $bits(alarm_pkg::buttons_t); i++) begin
                if (sync_q2[i] == stable[i]) begin
                    hold_cnt[i] <= '0;  // bounce back, start over
                end else if (hold_cnt[i] == DEBOUNCE_CLKS) begin
                    stable[i]   <= sync_q2[i];
                    press_q[i]  <= sync_q2[i];  // pulse on press only, not on release
                    hold_cnt[i] <= '0;
                end else begin
                    hold_cnt[i] <= hold_cnt[i] + 1'b1;
                end
            end
        end
    end

endmodule

/* verilog/tick_divider.sv */
`timescale 1ns/1ps

module tick_divider #(
    parameter int CLKS_PER_TICK = alarm_pkg::CLKS_PER_TICK_DEFAULT
) (
    input  logic clk,
    input  logic rst,
    output logic tick
);

    logic [$clog2(CLKS_PER_TICK)-1:0] div_cnt;

    always_ff @(posedge clk) begin
        if (rst) begin
            div_cnt <= '0;
            tick    <= 1'b0;
        end else begin
            if (div_cnt == CLKS_PER_TICK - 1) begin
                div_cnt <= '0;
                tick    <= 1'b1;
            end else begin
                div_cnt <= div_cnt + 1'b1;
                tick    <= 1'b0;
            end
        end
    end

endmodule

/* alarm_controller/alarm_controller.sv */
`timescale 1ns/1ps

module alarm_controller (
    input  logic                          clk,
    input  logic                          rst,
    input  alarm_pkg::buttons_t           presses,
    input  logic                          tick,
    input  logic [alarm_pkg::SWITCH_W-1:0] switches,
    output alarm_pkg::timer_status_t      status
);

    alarm_pkg::timer_state_t state;
    alarm_pkg::timer_state_t state_d;
    alarm_pkg::count_t       load_cs;
    alarm_pkg::count_t       count_d;

    // seconds from the switches, scaled to centiseconds
    assign load_cs = alarm_pkg::count_t'(switches) * alarm_pkg::count_t'(alarm_pkg::CS_PER_SEC);

    always_comb begin
        state_d = state;
        count_d = status.count_cs;
        case (state)
            alarm_pkg::SET: begin
                count_d = load_cs;  // track the switches while idle
                if (presses.pause) begin
                    // starting from zero goes straight to the alarm
                    state_d = (load_cs == '0) ? alarm_pkg::BEEP : alarm_pkg::RUN;
                end
            end
            alarm_pkg::RUN: begin
                if (presses.pause) begin
                    state_d = alarm_pkg::PAUSE;  // pause wins over clear
                end else if (presses.clear) begin
                    state_d = alarm_pkg::SET;
                    count_d = load_cs;
                end else if (tick) begin
                    if (status.count_cs <= alarm_pkg::count_t'(1)) begin
                        state_d = alarm_pkg::BEEP;
                        count_d = '0;
                    end else begin
                        count_d = status.count_cs - 1'b1;
                    end
                end
            end
            alarm_pkg::PAUSE: begin
                if (presses.pause) begin
                    state_d = alarm_pkg::RUN;  // count stays frozen until next tick
                end else if (presses.clear) begin
                    state_d = alarm_pkg::SET;
                    count_d = load_cs;
                end
            end
            alarm_pkg::BEEP: begin
                count_d = '0;
                if (presses.clear) begin
                    state_d = alarm_pkg::SET;
                    count_d = load_cs;
                end
            end
            default: begin
                state_d = alarm_pkg::SET;
                count_d = load_cs;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state  <= alarm_pkg::SET;
            status <= '0;
        end else begin
            state           <= state_d;
            status.count_cs <= count_d;
            status.flash    <= (state_d == alarm_pkg::PAUSE) || (state_d == alarm_pkg::BEEP);
            status.buzz     <= (state_d == alarm_pkg::BEEP);
        end
    end

endmodule

/* display/bcd_converter.sv */
`timescale 1ns/1ps

module bcd_converter (
    input  logic                          clk,
    input  logic                          rst,
    input  logic [alarm_pkg::COUNT_W-1:0] count_cs,
    output alarm_pkg::bcd_digits_t        digits,
    output logic                          digits_valid
);

    logic                          busy;
    logic [alarm_pkg::COUNT_W-1:0] last_bin;   // value of the last started conversion
    logic [alarm_pkg::COUNT_W-1:0] bin_sr;
    alarm_pkg::bcd_digits_t        bcd_work;
    alarm_pkg::bcd_digits_t        bcd_shifted;
    logic [$bits(alarm_pkg::bcd_digits_t)-1:0] bcd_adjusted;
    logic [$clog2(alarm_pkg::COUNT_W)-1:0] bit_cnt;

    // add 3 to every digit of 5 or more before the shift
    function automatic alarm_pkg::bcd_digits_t add3(input alarm_pkg::bcd_digits_t d);
        alarm_pkg::bcd_digits_t r;
        r = d;
        for (int i = 0; i < alarm_pkg::NUM_DIGITS; i++) begin
            if (d[i] >= 4'd5) begin
                r[i] = d[i] + 4'd3;
            end
        end
        return r;
    endfunction

    assign bcd_adjusted = add3(bcd_work);
    // digit 4 stays below 8, so its top bit drops out of the shift
    assign bcd_shifted  = {bcd_adjusted[$bits(alarm_pkg::bcd_digits_t)-2:0],
                           bin_sr[alarm_pkg::COUNT_W-1]};

    always_ff @(posedge clk) begin
        if (rst) begin
            busy         <= 1'b0;
            last_bin     <= '0;
            bit_cnt      <= '0;
            digits       <= '0;
            digits_valid <= 1'b0;
        end else begin
            digits_valid <= 1'b0;
            if (!busy) begin
                if (count_cs != last_bin) begin
                    busy     <= 1'b1;
                    last_bin <= count_cs;
                    bin_sr   <= count_cs;
                    bcd_work <= '0;
                    bit_cnt  <= '0;
                end
            end else begin
                bin_sr   <= bin_sr << 1;
                bcd_work <= bcd_shifted;
                bit_cnt  <= bit_cnt + 1'b1;
                if (bit_cnt == alarm_pkg::COUNT_W - 1) begin
                    busy         <= 1'b0;
                    digits       <= bcd_shifted;  // publish only the finished result
                    digits_valid <= 1'b1;
                end
            end
        end
    end

endmodule

/* display/display_driver.sv */
`timescale 1ns/1ps

module display_driver #(
    parameter int SCAN_CLKS = alarm_pkg::SCAN_CLKS_DEFAULT
) (
    input  logic                             clk,
    input  logic                             rst,
    input  alarm_pkg::bcd_digits_t           digits,
    input  logic                             digits_valid,
    input  logic                             flash,
    input  logic                             tick,
    output logic [6:0]                       seg,
    output logic                             dp,
    output logic [alarm_pkg::NUM_DIGITS-1:0] digit_en
);

    alarm_pkg::bcd_digits_t                          shown;
    logic [$clog2(SCAN_CLKS)-1:0]                    scan_cnt;
    logic [$clog2(alarm_pkg::NUM_DIGITS)-1:0]        digit_sel;
    logic [$clog2(alarm_pkg::NUM_DIGITS)-1:0]        next_sel;
    logic [$clog2(alarm_pkg::BLINK_TICKS)-1:0]       blink_cnt;
    logic                                            blink_off;
    logic                                            blank;

    // active low, bit order gfedcba
    function automatic logic [6:0] seg_code(input logic [3:0] d);
        case (d)
            4'd0:    return 7'b1000000;
            4'd1:    return 7'b1111001;
            4'd2:    return 7'b0100100;
            4'd3:    return 7'b0110000;
            4'd4:    return 7'b0011001;
            4'd5:    return 7'b0010010;
            4'd6:    return 7'b0000010;
            4'd7:    return 7'b1111000;
            4'd8:    return 7'b0000000;
            4'd9:    return 7'b0010000;
            default: return 7'b1111111;
        endcase
    endfunction

    assign next_sel = (digit_sel == alarm_pkg::NUM_DIGITS - 1) ? '0 : digit_sel + 1'b1;
    assign blank    = flash && blink_off;
    assign seg      = blank ? 7'b1111111 : seg_code(shown[digit_sel]);
    assign dp       = !((digit_sel == 2) && !blank);  // point between seconds and hundredths

    always_ff @(posedge clk) begin
        if (digits_valid) begin
            shown <= digits;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            scan_cnt  <= '0;
            digit_sel <= '0;
            digit_en  <= '1;  // all digits off until the first step
        end else if (scan_cnt == SCAN_CLKS - 1) begin
            scan_cnt  <= '0;
            digit_sel <= next_sel;
            digit_en  <= ~({{(alarm_pkg::NUM_DIGITS-1){1'b0}}, 1'b1} << next_sel);
        end else begin
            scan_cnt <= scan_cnt + 1'b1;
        end
    end

    // blink phase restarts in the on half each time flash is raised
    always_ff @(posedge clk) begin
        if (rst || !flash) begin
            blink_cnt <= '0;
            blink_off <= 1'b0;
        end else if (tick) begin
            if (blink_cnt == alarm_pkg::BLINK_TICKS - 1) begin
                blink_cnt <= '0;
                blink_off <= !blink_off;
            end else begin
                blink_cnt <= blink_cnt + 1'b1;
            end
        end
    end

endmodule

/* verilog/buzzer_tone.sv */
`timescale 1ns/1ps

module buzzer_tone #(
    parameter int TONE_HALF_CLKS = alarm_pkg::TONE_HALF_CLKS_DEFAULT
) (
    input  logic clk,
    input  logic rst,
    input  logic buzz,
    output logic buzzer
);

    logic [$clog2(TONE_HALF_CLKS)-1:0] half_cnt;

    always_ff @(posedge clk) begin
        if (rst || !buzz) begin
            half_cnt <= '0;
            buzzer   <= 1'b0;  // silent and low when not alarming
        end else if (half_cnt == TONE_HALF_CLKS - 1) begin
            half_cnt <= '0;
            buzzer   <= !buzzer;
        end else begin
            half_cnt <= half_cnt + 1'b1;
        end
    end

endmodule

/* verilog/alarm_timer_top.sv */
`timescale 1ns/1ps

module alarm_timer_top #(
    parameter int CLKS_PER_TICK  = alarm_pkg::CLKS_PER_TICK_DEFAULT,
    parameter int DEBOUNCE_CLKS  = alarm_pkg::DEBOUNCE_CLKS_DEFAULT,
    parameter int SCAN_CLKS      = alarm_pkg::SCAN_CLKS_DEFAULT,
    parameter int TONE_HALF_CLKS = alarm_pkg::TONE_HALF_CLKS_DEFAULT
) (
    input  logic                             clk,
    input  logic                             rst,
    input  alarm_pkg::buttons_t              buttons,
    input  logic [alarm_pkg::SWITCH_W-1:0]   switches,
    output logic [6:0]                       seg,
    output logic                             dp,
    output logic [alarm_pkg::NUM_DIGITS-1:0] digit_en,
    output logic                             buzzer,
    output alarm_pkg::timer_status_t         status     // also drives the board LEDs
);

    alarm_pkg::buttons_t    presses;
    alarm_pkg::bcd_digits_t digits;
    logic                   digits_valid;
    logic                   tick;

    button_conditioner #(.DEBOUNCE_CLKS(DEBOUNCE_CLKS)) button_conditioner_inst (
        .clk     (clk),
        .rst     (rst),
        .buttons (buttons),
        .presses (presses)
    );

    tick_divider #(.CLKS_PER_TICK(CLKS_PER_TICK)) tick_divider_inst (
        .clk  (clk),
        .rst  (rst),
        .tick (tick)
    );

    alarm_controller alarm_controller_inst (
        .clk      (clk),
        .rst      (rst),
        .presses  (presses),
        .tick     (tick),
        .switches (switches),
        .status   (status)
    );

    bcd_converter bcd_converter_inst (
        .clk          (clk),
        .rst          (rst),
        .count_cs     (status.count_cs),
        .digits       (digits),
        .digits_valid (digits_valid)
    );

    display_driver #(.SCAN_CLKS(SCAN_CLKS)) display_driver_inst (
        .clk          (clk),
        .rst          (rst),
        .digits       (digits),
        .digits_valid (digits_valid),
        .flash        (status.flash),
        .tick         (tick),
        .seg          (seg),
        .dp           (dp),
        .digit_en     (digit_en)
    );

    buzzer_tone #(.TONE_HALF_CLKS(TONE_HALF_CLKS)) buzzer_tone_inst (
        .clk    (clk),
        .rst    (rst),
        .buzz   (status.buzz),
        .buzzer (buzzer)
    );

endmodule

/* test/alarm_timer_asserts.sv */
`timescale 1ns/1ps

module alarm_timer_asserts (
    input logic                           clk,
    input logic                           rst,
    input alarm_pkg::timer_state_t        state,
    input logic [alarm_pkg::SWITCH_W-1:0] switches,
    input alarm_pkg::timer_status_t       status
);

    buzz_implies_flash: assert property (@(posedge clk) disable iff (rst)
        status.buzz |-> status.flash)
        else $error("buzz set while flash is clear");

    buzz_implies_zero: assert property (@(posedge clk) disable iff (rst)
        status.buzz |-> (status.count_cs == '0))
        else $error("buzz set with a nonzero count");

    // pause, clear and reload all leave RUN, so a rising count in RUN is a bug
    run_never_counts_up: assert property (@(posedge clk) disable iff (rst)
        (state == alarm_pkg::RUN && $past(state) == alarm_pkg::RUN)
            |-> (status.count_cs <= $past(status.count_cs)))
        else $error("count increased while running");

    set_follows_switches: assert property (@(posedge clk) disable iff (rst)
        (state == alarm_pkg::SET && switches != $past(switches))
            |=> (status.count_cs == $past(switches) * alarm_pkg::CS_PER_SEC))
        else $error("count did not follow the switches in SET");

endmodule

bind alarm_controller alarm_timer_asserts alarm_timer_asserts_inst (
    .clk      (clk),
    .rst      (rst),
    .state    (state),
    .switches (switches),
    .status   (status)
);

/* test/tb_alarm_timer.sv */
`timescale 1ns/1ps

module tb_alarm_timer;

    localparam int CLK_PERIOD     = 10;
    localparam int RESET_CYCLES   = 16;
    localparam int CLKS_PER_TICK  = 20;
    localparam int DEBOUNCE_CLKS  = 4;
    localparam int SCAN_CLKS      = 3;
    localparam int TONE_HALF_CLKS = 5;
    localparam int HOLD_CLKS      = DEBOUNCE_CLKS + 4;
    localparam int CS             = alarm_pkg::CS_PER_SEC;
    localparam int ALARM_CLKS     = (CS + 2) * CLKS_PER_TICK;
    localparam int BLINK_CLKS     = (2 * alarm_pkg::BLINK_TICKS + 2) * CLKS_PER_TICK;
    localparam int TEST_CLKS      = RESET_CYCLES + 32 * HOLD_CLKS + 40 * CLKS_PER_TICK
                                    + ALARM_CLKS + BLINK_CLKS + 500;

    logic                             clk;
    logic                             rst;
    alarm_pkg::buttons_t              buttons;
    logic [alarm_pkg::SWITCH_W-1:0]   switches;
    logic [6:0]                       seg;
    logic                             dp;
    logic [alarm_pkg::NUM_DIGITS-1:0] digit_en;
    logic                             buzzer;
    alarm_pkg::timer_status_t         status;

    int cycle = 0;   // rising edges so far
    int press_edge;  // edge after which the last press has taken effect
    int start_cs;    // count at the start of the current run
    int errors = 0;
    int checks = 0;
    int tests  = 0;

    alarm_timer_top #(
        .CLKS_PER_TICK  (CLKS_PER_TICK),
        .DEBOUNCE_CLKS  (DEBOUNCE_CLKS),
        .SCAN_CLKS      (SCAN_CLKS),
        .TONE_HALF_CLKS (TONE_HALF_CLKS)
    ) alarm_timer_top_inst (
        .clk      (clk),
        .rst      (rst),
        .buttons  (buttons),
        .switches (switches),
        .seg      (seg),
        .dp       (dp),
        .digit_en (digit_en),
        .buzzer   (buzzer),
        .status   (status)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk) cycle <= cycle + 1;

    initial begin
        #(2 * TEST_CLKS * CLK_PERIOD);
        $display("watchdog expired after %0d cycles, the tests never finished", 2 * TEST_CLKS);
        $display("SIMULATION FAILED");
        $finish;
    end

    task automatic check_value(input string name, input int expected, input int actual,
                               input int tol);
        int diff;
        diff = (expected > actual) ? expected - actual : actual - expected;
        checks++;
        if (diff > tol) begin
            errors++;
            $display("Error at %0t: %s expected %0d, got %0d", $time, name, expected, actual);
        end
    endtask

    task automatic check_status(input int count, input int count_tol, input int flash,
                                input int buzz);
        check_value("status.count_cs", count, status.count_cs, count_tol);
        check_value("status.flash", flash, status.flash, 0);
        check_value("status.buzz", buzz, status.buzz, 0);
    endtask

    task automatic report_test(input string name, input int start_errors);
        tests++;
        $display("%s: %0d errors", name, errors - start_errors);
    endtask

    // active low gfedcba, built from the lit segments of each numeral
    function automatic logic [6:0] segment_pattern(input int digit);
        logic [6:0] lit;
        case (digit)
            0:       lit = 7'b0111111;
            1:       lit = 7'b0000110;
            2:       lit = 7'b1011011;
            3:       lit = 7'b1001111;
            4:       lit = 7'b1100110;
            5:       lit = 7'b1101101;
            6:       lit = 7'b1111101;
            7:       lit = 7'b0000111;
            8:       lit = 7'b1111111;
            9:       lit = 7'b1101111;
            default: lit = 7'b0000000;
        endcase
        return ~lit;
    endfunction

    task automatic press_button(input bit use_clear);
        @(posedge clk);
        press_edge = cycle + DEBOUNCE_CLKS + 5;  // sync, debounce, pulse, then state
        if (use_clear) begin
            buttons.clear <= 1'b1;
        end else begin
            buttons.pause <= 1'b1;
        end
        repeat (HOLD_CLKS) @(posedge clk);
        buttons <= '0;
        repeat (HOLD_CLKS) @(posedge clk);  // let the release settle
        @(negedge clk);
    endtask

    task automatic set_switches(input int value);
        @(posedge clk);
        switches <= value;
        repeat (2) @(posedge clk);
        @(negedge clk);
    endtask

    function automatic int ticks_since(input int edge_ref);
        return (cycle - edge_ref) / CLKS_PER_TICK;
    endfunction

    task automatic test_set_loading();
        int start_errors;
        int sw;
        start_errors = errors;
        check_status(switches * CS, 0, 0, 0);
        repeat (6) begin
            sw = $urandom % 512;
            set_switches(sw);
            check_status(sw * CS, 0, 0, 0);
        end
        report_test("set loading", start_errors);
    endtask

    task automatic test_countdown();
        int start_errors;
        int sw;
        start_errors = errors;
        sw = ($urandom % 500) + 10;
        set_switches(sw);
        start_cs = sw * CS;
        press_button(1'b0);
        repeat (5) begin
            repeat (2 * CLKS_PER_TICK) @(negedge clk);
            check_status(start_cs - ticks_since(press_edge), 1, 0, 0);
        end
        report_test("countdown", start_errors);
    endtask

    task automatic test_pause_resume();
        int start_errors;
        int run1;
        int frozen;
        start_errors = errors;
        run1 = press_edge;
        press_button(1'b0);
        run1 = press_edge - 1 - run1;  // clocks spent counting before the pause
        check_status(start_cs - run1 / CLKS_PER_TICK, 1, 1, 0);
        frozen = status.count_cs;
        repeat (5 * CLKS_PER_TICK) @(negedge clk);
        check_value("status.count_cs", frozen, status.count_cs, 0);
        check_value("status.flash", 1, status.flash, 0);
        press_button(1'b0);
        check_value("status.flash", 0, status.flash, 0);
        repeat (3 * CLKS_PER_TICK) @(negedge clk);
        check_status(start_cs - (run1 + cycle - press_edge) / CLKS_PER_TICK, 2, 0, 0);
        report_test("pause and resume", start_errors);
    endtask

    task automatic test_alarm();
        int start_errors;
        int waited;
        int toggles;
        logic prev;
        start_errors = errors;
        press_button(1'b1);
        set_switches(1);
        check_status(CS, 0, 0, 0);
        press_button(1'b0);
        waited = 0;
        while (!status.buzz && waited < ALARM_CLKS) begin
            check_value("buzzer", 0, buzzer, 0);  // silent until the alarm
            @(negedge clk);
            waited++;
        end
        if (!status.buzz) begin
            errors++;
            $display("alarm never sounded within %0d cycles of the start", ALARM_CLKS);
        end else begin
            check_status(0, 0, 1, 1);
            check_value("ticks to alarm", CS, ticks_since(press_edge), 1);
            toggles = 0;
            prev = buzzer;
            repeat (10 * TONE_HALF_CLKS) begin
                @(negedge clk);
                if (buzzer !== prev) toggles++;
                prev = buzzer;
            end
            check_value("buzzer toggles", 10, toggles, 1);
        end
        report_test("alarm", start_errors);
    endtask

    task automatic clear_with_new_switches();
        int sw;
        sw = ($urandom % 511) + 1;
        set_switches(sw);
        press_button(1'b1);
        check_status(sw * CS, 0, 0, 0);
        check_value("buzzer", 0, buzzer, 0);
    endtask

    task automatic test_clear();
        int start_errors;
        start_errors = errors;
        clear_with_new_switches();  // from BEEP
        press_button(1'b0);
        repeat (3 * CLKS_PER_TICK) @(negedge clk);
        clear_with_new_switches();  // from RUN
        press_button(1'b0);
        press_button(1'b0);
        check_value("status.flash", 1, status.flash, 0);
        clear_with_new_switches();  // from PAUSE
        report_test("clear", start_errors);
    endtask

    task automatic test_display();
        int start_errors;
        int sw;
        int value;
        int waited;
        logic [alarm_pkg::NUM_DIGITS-1:0] want_en;
        start_errors = errors;
        sw = ($urandom % 511) + 1;
        set_switches(sw);
        value = sw * CS;
        // an earlier conversion may still be running ahead of this one
        repeat (2 * (alarm_pkg::COUNT_W + 1) + 4) @(negedge clk);
        for (int k = 0; k < alarm_pkg::NUM_DIGITS; k++) begin
            want_en = '1;
            want_en[k] = 1'b0;
            waited = 0;
            while (digit_en !== want_en && waited < 4 * alarm_pkg::NUM_DIGITS * SCAN_CLKS) begin
                @(negedge clk);
                waited++;
            end
            if (digit_en !== want_en) begin
                errors++;
                $display("digit %0d was never enabled by the scan", k);
            end else begin
                check_value("seg", segment_pattern(value % 10), seg, 0);
                check_value("dp", (k == 2) ? 0 : 1, dp, 0);
            end
            value = value / 10;
        end
        press_button(1'b0);
        press_button(1'b0);
        waited = 0;
        while (seg !== 7'h7f && waited < BLINK_CLKS) begin
            @(negedge clk);
            waited++;
        end
        if (seg !== 7'h7f) begin
            errors++;
            $display("display never blanked while paused");
        end else begin
            check_value("dp", 1, dp, 0);
        end
        press_button(1'b1);
        report_test("display", start_errors);
    endtask

    initial begin
        void'($urandom(32'h9af23ecc));
        rst      = 1'b1;
        buttons  = '0;
        switches = $urandom % 512;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        test_set_loading();
        test_countdown();
        test_pause_resume();
        test_alarm();
        test_clear();
        test_display();
        $display("tests: %0d, checks: %0d, errors: %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

/* project.f */
common/alarm_pkg.sv
verilog/button_conditioner.sv
verilog/tick_divider.sv
alarm_controller/alarm_controller.sv
display/bcd_converter.sv
display/display_driver.sv
verilog/buzzer_tone.sv
verilog/alarm_timer_top.sv
test/alarm_timer_asserts.sv
test/tb_alarm_timer.sv
